//--- Makefile
TOP := chip8_exec_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert --timing -j 0 --top-module $(TOP) -f sources.f -Mdir obj_dir -o $(TOP)

run: compile
	./obj_dir/$(TOP) +verilator+error+limit+1000 | tee sim.log
	@if grep -qF "*** TEST FAILED ***" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -qF "*** TEST PASSED ***" sim.log || { echo "simulation did not complete"; exit 1; }

clean:
	rm -rf obj_dir sim.log

//--- hdl/chip8_alu.sv
// Combinational data unit; vx and vy must be the registered reads for the word on instr
`timescale 1ns/1ps

module chip8_alu (
	input  chip8_isa_pkg::instr_t               instr,
	input  logic [chip8_core_pkg::DATA_W-1:0]   vx,
	input  logic [chip8_core_pkg::DATA_W-1:0]   vy,
	input  logic [chip8_core_pkg::ADDR_W-1:0]   i_cur,
	output logic [chip8_core_pkg::DATA_W-1:0]   result,
	output logic                                flag,
	output logic                                flag_we,
	output logic                                res_we,
	output logic [chip8_core_pkg::ADDR_W-1:0]   i_next,
	output logic                                i_we
);

	localparam int DW = chip8_core_pkg::DATA_W;
	localparam int AW = chip8_core_pkg::ADDR_W;

	chip8_core_pkg::alu_op_e op;
	logic [DW-1:0]           opnd_b;
	logic [DW:0]             sum;

	// Decode class and function into an operation and its second operand
	always_comb begin
		op      = chip8_core_pkg::ALU_MOV;
		opnd_b  = vy;
		res_we  = 1'b0;
		flag_we = 1'b0;
		i_we    = 1'b0;
		i_next  = i_cur;
		case (instr.rg.cls)
			chip8_isa_pkg::CLS_LD_IMM: begin
				opnd_b = instr.imm.kk;
				res_we = 1'b1;
			end
			chip8_isa_pkg::CLS_ADD_IMM: begin
				// Immediate add leaves VF alone
				op     = chip8_core_pkg::ALU_ADD;
				opnd_b = instr.imm.kk;
				res_we = 1'b1;
			end
			chip8_isa_pkg::CLS_ALU: begin
				res_we = 1'b1;
				case (instr.rg.fn)
					chip8_isa_pkg::FN_MOV:  op = chip8_core_pkg::ALU_MOV;
					chip8_isa_pkg::FN_OR:   op = chip8_core_pkg::ALU_OR;
					chip8_isa_pkg::FN_AND:  op = chip8_core_pkg::ALU_AND;
					chip8_isa_pkg::FN_XOR:  op = chip8_core_pkg::ALU_XOR;
					chip8_isa_pkg::FN_ADD: begin
						op      = chip8_core_pkg::ALU_ADD;
						flag_we = 1'b1;
					end
					chip8_isa_pkg::FN_SUB: begin
						op      = chip8_core_pkg::ALU_SUB;
						flag_we = 1'b1;
					end
					chip8_isa_pkg::FN_SUBN: begin
						op      = chip8_core_pkg::ALU_SUBN;
						flag_we = 1'b1;
					end
					chip8_isa_pkg::FN_SHR: begin
						op      = chip8_core_pkg::ALU_SHR;
						flag_we = 1'b1;
					end
					chip8_isa_pkg::FN_SHL: begin
						op      = chip8_core_pkg::ALU_SHL;
						flag_we = 1'b1;
					end
					// Unlisted 8xy codes write nothing
					default: res_we = 1'b0;
				endcase
			end
			chip8_isa_pkg::CLS_LD_I: begin
				i_next = instr.addr.nnn;
				i_we   = 1'b1;
			end
			chip8_isa_pkg::CLS_MISC_F: begin
				case (instr.imm.kk)
					chip8_isa_pkg::FSEL_ADD_I: begin
						// Wraps at 12 bits
						i_next = i_cur + {{(AW-DW){1'b0}}, vx};
						i_we   = 1'b1;
					end
					chip8_isa_pkg::FSEL_LD_F: begin
						// Glyph base, low nibble of Vx only
						i_next = {{(AW-4){1'b0}}, vx[3:0]} *
							{{(AW-4){1'b0}}, chip8_isa_pkg::FONT_STRIDE};
						i_we   = 1'b1;
					end
					default: ;
				endcase
			end
			default: ;
		endcase
	end

	// Result and flag
	always_comb begin
		sum    = {1'b0, vx} + {1'b0, opnd_b};
		result = opnd_b;
		flag   = 1'b0;
		case (op)
			chip8_core_pkg::ALU_ADD: begin
				result = sum[DW-1:0];
				flag   = sum[DW];
			end
			chip8_core_pkg::ALU_SUB: begin
				// Not-borrow
				result = vx - opnd_b;
				flag   = (vx >= opnd_b);
			end
			chip8_core_pkg::ALU_SUBN: begin
				result = opnd_b - vx;
				flag   = (opnd_b >= vx);
			end
			chip8_core_pkg::ALU_OR:  result = vx | opnd_b;
			chip8_core_pkg::ALU_AND: result = vx & opnd_b;
			chip8_core_pkg::ALU_XOR: result = vx ^ opnd_b;
			chip8_core_pkg::ALU_SHR: begin
				// Shifted-out bit of Vx
				result = vx >> 1;
				flag   = vx[0];
			end
			chip8_core_pkg::ALU_SHL: begin
				result = vx << 1;
				flag   = vx[DW-1];
			end
			default: result = opnd_b;
		endcase
	end

endmodule

//--- hdl/chip8_branch.sv
// Combinational flow unit; for Bnnn the vx input must carry V0, other opcodes fall through to pc+2
`timescale 1ns/1ps

module chip8_branch (
	input  chip8_isa_pkg::instr_t               instr,
	input  logic [chip8_core_pkg::DATA_W-1:0]   vx,
	input  logic [chip8_core_pkg::DATA_W-1:0]   vy,
	input  logic [chip8_core_pkg::ADDR_W-1:0]   pc_cur,
	output logic [chip8_core_pkg::ADDR_W-1:0]   pc_next
);

	localparam int AW = chip8_core_pkg::ADDR_W;
	localparam int DW = chip8_core_pkg::DATA_W;

	// One instruction is two bytes
	localparam logic [AW-1:0] STEP = 2;

	chip8_core_pkg::pc_sel_e sel;

	// Skip conditions and jumps
	always_comb begin
		sel = chip8_core_pkg::PC_NEXT;
		case (instr.rg.cls)
			chip8_isa_pkg::CLS_JP:    sel = chip8_core_pkg::PC_JUMP;
			chip8_isa_pkg::CLS_JP_V0: sel = chip8_core_pkg::PC_JUMP_V0;
			chip8_isa_pkg::CLS_SE_IMM: begin
				if (vx == instr.imm.kk) sel = chip8_core_pkg::PC_SKIP;
			end
			chip8_isa_pkg::CLS_SNE_IMM: begin
				if (vx != instr.imm.kk) sel = chip8_core_pkg::PC_SKIP;
			end
			// Register compares only defined with a zero low nibble
			chip8_isa_pkg::CLS_SE_REG: begin
				if (instr.rg.fn == '0 && vx == vy) sel = chip8_core_pkg::PC_SKIP;
			end
			chip8_isa_pkg::CLS_SNE_REG: begin
				if (instr.rg.fn == '0 && vx != vy) sel = chip8_core_pkg::PC_SKIP;
			end
			default: ;
		endcase
	end

	// Target, all sums wrap at 12 bits
	always_comb begin
		case (sel)
			chip8_core_pkg::PC_SKIP:    pc_next = pc_cur + STEP + STEP;
			chip8_core_pkg::PC_JUMP:    pc_next = instr.addr.nnn;
			chip8_core_pkg::PC_JUMP_V0: pc_next = instr.addr.nnn + {{(AW-DW){1'b0}}, vx};
			default:                    pc_next = pc_cur + STEP;
		endcase
	end

endmodule

//--- hdl/chip8_core_pkg.sv
// Datapath widths and the internal select codes shared by the execute core blocks
package chip8_core_pkg;

	// Index and program counter width
	localparam int ADDR_W = 12;

	// V register width
	localparam int DATA_W = 8;

	// Number of V registers, one per value of the x field
	localparam int REG_COUNT = 2 ** chip8_isa_pkg::REG_W;

	// Data unit operation
	// Nine operations, so one bit more than three
	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SUBN,
		ALU_OR,
		ALU_AND,
		ALU_XOR,
		ALU_SHR,
		ALU_SHL,
		ALU_MOV
	} alu_op_e;

	// Next PC source
	typedef enum logic [1:0] {
		PC_NEXT,
		PC_SKIP,
		PC_JUMP,
		PC_JUMP_V0
	} pc_sel_e;

endpackage

//--- hdl/chip8_exec_top.sv
// Chip-8 execute core without memory, display, keypad or timers; PC and I only change via opcodes
`timescale 1ns/1ps

module chip8_exec_top #(
	parameter logic [chip8_core_pkg::ADDR_W-1:0] PC_RESET = 12'h200
) (
	input  logic                                cpu_clk,
	input  logic                                arst_n,
	input  logic                                instr_valid,
	input  chip8_isa_pkg::instr_t               instr,
	output logic                                ready,
	output logic                                done,
	output logic [chip8_core_pkg::ADDR_W-1:0]   pc,
	output logic [chip8_core_pkg::ADDR_W-1:0]   i_reg,
	input  logic [chip8_isa_pkg::REG_W-1:0]     peek_addr,
	output logic [chip8_core_pkg::DATA_W-1:0]   peek_data
);

	localparam int DW = chip8_core_pkg::DATA_W;
	localparam int AW = chip8_core_pkg::ADDR_W;
	localparam int RW = chip8_isa_pkg::REG_W;

	chip8_isa_pkg::instr_t lat_instr;

	// Register file ports
	logic [RW-1:0] rd_addr_a;
	logic [RW-1:0] rd_addr_b;
	logic [DW-1:0] rd_data_a;
	logic [DW-1:0] rd_data_b;
	logic          wr_en_res;
	logic [RW-1:0] wr_addr_res;
	logic [DW-1:0] wr_data_res;
	logic          wr_en_flag;
	logic          wr_data_flag;

	// Unit results toward retire
	logic [DW-1:0] result;
	logic          flag;
	logic          flag_we;
	logic          res_we;
	logic [AW-1:0] i_next;
	logic          i_we;
	logic [AW-1:0] pc_next;

	chip8_reg_file reg_file_i (
		.cpu_clk      (cpu_clk),
		.arst_n       (arst_n),
		.rd_addr_a    (rd_addr_a),
		.rd_addr_b    (rd_addr_b),
		.rd_data_a    (rd_data_a),
		.rd_data_b    (rd_data_b),
		.wr_en_res    (wr_en_res),
		.wr_addr_res  (wr_addr_res),
		.wr_data_res  (wr_data_res),
		.wr_en_flag   (wr_en_flag),
		.wr_data_flag (wr_data_flag),
		.peek_addr    (peek_addr),
		.peek_data    (peek_data)
	);

	// Both units see the same latched word and operands
	chip8_alu alu_i (
		.instr   (lat_instr),
		.vx      (rd_data_a),
		.vy      (rd_data_b),
		.i_cur   (i_reg),
		.result  (result),
		.flag    (flag),
		.flag_we (flag_we),
		.res_we  (res_we),
		.i_next  (i_next),
		.i_we    (i_we)
	);

	chip8_branch branch_i (
		.instr   (lat_instr),
		.vx      (rd_data_a),
		.vy      (rd_data_b),
		.pc_cur  (pc),
		.pc_next (pc_next)
	);

	chip8_retire #(
		.PC_RESET (PC_RESET)
	) retire_i (
		.cpu_clk      (cpu_clk),
		.arst_n       (arst_n),
		.instr_valid  (instr_valid),
		.instr        (instr),
		.ready        (ready),
		.done         (done),
		.lat_instr    (lat_instr),
		.rd_addr_a    (rd_addr_a),
		.rd_addr_b    (rd_addr_b),
		.result       (result),
		.flag         (flag),
		.flag_we      (flag_we),
		.res_we       (res_we),
		.i_next       (i_next),
		.i_we         (i_we),
		.pc_next      (pc_next),
		.wr_en_res    (wr_en_res),
		.wr_addr_res  (wr_addr_res),
		.wr_data_res  (wr_data_res),
		.wr_en_flag   (wr_en_flag),
		.wr_data_flag (wr_data_flag),
		.pc           (pc),
		.i_reg        (i_reg)
	);

endmodule

//--- hdl/chip8_isa_pkg.sv
// Chip-8 instruction word layout; only the classes this core executes get a named code
package chip8_isa_pkg;

	// Field widths of the 16-bit instruction word
	localparam int CLS_W = 4;
	localparam int REG_W = 4;
	localparam int KK_W  = 8;
	localparam int NNN_W = 12;
	localparam int FN_W  = 4;

	// One word, three readings of the same bits
	typedef union packed {
		// Address view for 1nnn, Annn, Bnnn
		struct packed {
			logic [CLS_W-1:0] cls;
			logic [NNN_W-1:0] nnn;
		} addr;
		// Immediate view for 3xkk, 4xkk, 6xkk, 7xkk and the Fx selectors
		struct packed {
			logic [CLS_W-1:0] cls;
			logic [REG_W-1:0] x;
			logic [KK_W-1:0]  kk;
		} imm;
		// Register view for 5xy0, 8xyn, 9xy0
		struct packed {
			logic [CLS_W-1:0] cls;
			logic [REG_W-1:0] x;
			logic [REG_W-1:0] y;
			logic [FN_W-1:0]  fn;
		} rg;
	} instr_t;

	// Class nibble, top four bits
	localparam logic [CLS_W-1:0] CLS_JP      = 4'h1;
	localparam logic [CLS_W-1:0] CLS_SE_IMM  = 4'h3;
	localparam logic [CLS_W-1:0] CLS_SNE_IMM = 4'h4;
	localparam logic [CLS_W-1:0] CLS_SE_REG  = 4'h5;
	localparam logic [CLS_W-1:0] CLS_LD_IMM  = 4'h6;
	localparam logic [CLS_W-1:0] CLS_ADD_IMM = 4'h7;
	localparam logic [CLS_W-1:0] CLS_ALU     = 4'h8;
	localparam logic [CLS_W-1:0] CLS_SNE_REG = 4'h9;
	localparam logic [CLS_W-1:0] CLS_LD_I    = 4'hA;
	localparam logic [CLS_W-1:0] CLS_JP_V0   = 4'hB;
	localparam logic [CLS_W-1:0] CLS_MISC_F  = 4'hF;

	// 8xy group, low nibble
	localparam logic [FN_W-1:0] FN_MOV  = 4'h0;
	localparam logic [FN_W-1:0] FN_OR   = 4'h1;
	localparam logic [FN_W-1:0] FN_AND  = 4'h2;
	localparam logic [FN_W-1:0] FN_XOR  = 4'h3;
	localparam logic [FN_W-1:0] FN_ADD  = 4'h4;
	localparam logic [FN_W-1:0] FN_SUB  = 4'h5;
	localparam logic [FN_W-1:0] FN_SHR  = 4'h6;
	localparam logic [FN_W-1:0] FN_SUBN = 4'h7;
	localparam logic [FN_W-1:0] FN_SHL  = 4'hE;

	// Fx group, low byte
	localparam logic [KK_W-1:0] FSEL_ADD_I = 8'h1E;
	localparam logic [KK_W-1:0] FSEL_LD_F  = 8'h29;

	// Bytes per font glyph, and the flag register
	localparam logic [3:0]       FONT_STRIDE = 4'd5;
	localparam logic [REG_W-1:0] VF_INDEX    = 4'hF;

endpackage

//--- hdl/chip8_reg_file.sv
// V0-VF in flops; reads land one cycle after the address, a VF write overrides a result write to VF
`timescale 1ns/1ps

module chip8_reg_file (
	input  logic                                cpu_clk,
	input  logic                                arst_n,
	input  logic [chip8_isa_pkg::REG_W-1:0]     rd_addr_a,
	input  logic [chip8_isa_pkg::REG_W-1:0]     rd_addr_b,
	output logic [chip8_core_pkg::DATA_W-1:0]   rd_data_a,
	output logic [chip8_core_pkg::DATA_W-1:0]   rd_data_b,
	input  logic                                wr_en_res,
	input  logic [chip8_isa_pkg::REG_W-1:0]     wr_addr_res,
	input  logic [chip8_core_pkg::DATA_W-1:0]   wr_data_res,
	input  logic                                wr_en_flag,
	input  logic                                wr_data_flag,
	input  logic [chip8_isa_pkg::REG_W-1:0]     peek_addr,
	output logic [chip8_core_pkg::DATA_W-1:0]   peek_data
);

	localparam int DW = chip8_core_pkg::DATA_W;

	logic [DW-1:0] v_regs [chip8_core_pkg::REG_COUNT];

	always_ff @(posedge cpu_clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < chip8_core_pkg::REG_COUNT; i++) begin
				v_regs[i] <= '0;
			end
			rd_data_a <= '0;
			rd_data_b <= '0;
		end else begin
			// Registered read ports, old value on a same-edge write
			rd_data_a <= v_regs[rd_addr_a];
			rd_data_b <= v_regs[rd_addr_b];
			if (wr_en_res) begin
				v_regs[wr_addr_res] <= wr_data_res;
			end
			// Later assignment, so VF wins when x is F
			if (wr_en_flag) begin
				v_regs[chip8_isa_pkg::VF_INDEX] <= {{(DW-1){1'b0}}, wr_data_flag};
			end
		end
	end

	// Host inspection, straight from the flops
	assign peek_data = v_regs[peek_addr];

endmodule

//--- hdl/chip8_retire.sv
// One instruction in flight; a strobe while ready is low is dropped, done pulses 3 edges after accept
`timescale 1ns/1ps

module chip8_retire #(
	parameter logic [chip8_core_pkg::ADDR_W-1:0] PC_RESET = 12'h200
) (
	input  logic                                cpu_clk,
	input  logic                                arst_n,
	input  logic                                instr_valid,
	input  chip8_isa_pkg::instr_t               instr,
	output logic                                ready,
	output logic                                done,
	output chip8_isa_pkg::instr_t               lat_instr,
	output logic [chip8_isa_pkg::REG_W-1:0]     rd_addr_a,
	output logic [chip8_isa_pkg::REG_W-1:0]     rd_addr_b,
	input  logic [chip8_core_pkg::DATA_W-1:0]   result,
	input  logic                                flag,
	input  logic                                flag_we,
	input  logic                                res_we,
	input  logic [chip8_core_pkg::ADDR_W-1:0]   i_next,
	input  logic                                i_we,
	input  logic [chip8_core_pkg::ADDR_W-1:0]   pc_next,
	output logic                                wr_en_res,
	output logic [chip8_isa_pkg::REG_W-1:0]     wr_addr_res,
	output logic [chip8_core_pkg::DATA_W-1:0]   wr_data_res,
	output logic                                wr_en_flag,
	output logic                                wr_data_flag,
	output logic [chip8_core_pkg::ADDR_W-1:0]   pc,
	output logic [chip8_core_pkg::ADDR_W-1:0]   i_reg
);

	// Idle, then read, commit and done, one cycle each
	localparam logic [1:0] ST_IDLE   = 2'd0;
	localparam logic [1:0] ST_READ   = 2'd1;
	localparam logic [1:0] ST_COMMIT = 2'd2;
	localparam logic [1:0] ST_DONE   = 2'd3;

	logic [1:0] stage;
	logic       accept;
	logic       commit;

	assign ready  = (stage == ST_IDLE);
	assign done   = (stage == ST_DONE);
	assign accept = instr_valid && ready;
	assign commit = (stage == ST_COMMIT);

	// Operand addresses, V0 stands in for Vx on Bnnn
	assign rd_addr_a = (lat_instr.rg.cls == chip8_isa_pkg::CLS_JP_V0) ? '0 : lat_instr.rg.x;
	assign rd_addr_b = lat_instr.rg.y;

	// Register writes land on the commit edge
	assign wr_en_res    = commit && res_we;
	assign wr_addr_res  = lat_instr.rg.x;
	assign wr_data_res  = result;
	assign wr_en_flag   = commit && flag_we;
	assign wr_data_flag = flag;

	always_ff @(posedge cpu_clk or negedge arst_n) begin
		if (!arst_n) begin
			stage     <= ST_IDLE;
			lat_instr <= '0;
			pc        <= PC_RESET;
			i_reg     <= '0;
		end else begin
			case (stage)
				ST_IDLE: begin
					if (accept) begin
						lat_instr <= instr;
						stage     <= ST_READ;
					end
				end
				// Read data gets registered on this edge
				ST_READ: stage <= ST_COMMIT;
				ST_COMMIT: begin
					stage <= ST_DONE;
					pc    <= pc_next;
					if (i_we) begin
						i_reg <= i_next;
					end
				end
				default: stage <= ST_IDLE;
			endcase
		end
	end

endmodule

//--- sources.f
hdl/chip8_isa_pkg.sv
hdl/chip8_core_pkg.sv
hdl/chip8_reg_file.sv
hdl/chip8_alu.sv
hdl/chip8_branch.sv
hdl/chip8_retire.sv
hdl/chip8_exec_top.sv
tests/tb_clock_gen.sv
tests/chip8_exec_props.sv
tests/chip8_exec_tb.sv

//--- tests/chip8_exec_props.sv
// Handshake timing checks bound into chip8_exec_top; fail_count is read by the testbench summary
`timescale 1ns/1ps

module chip8_exec_props (
	input logic                                cpu_clk,
	input logic                                arst_n,
	input logic                                instr_valid,
	input logic                                ready,
	input logic                                done,
	input logic [chip8_core_pkg::ADDR_W-1:0]   pc
);

	int unsigned fail_count;
	logic        accept;

	assign accept = instr_valid && ready;

	initial fail_count = 0;

	// Done seen on the third edge after the accepting edge
	accept_to_done: assert property (@(posedge cpu_clk) disable iff (!arst_n)
		accept |-> ##1 !done ##1 !done ##1 done)
	else begin
		$error("done did not follow acceptance by exactly three cycles");
		fail_count++;
	end

	// Busy window of three cycles, then ready again
	ready_low_window: assert property (@(posedge cpu_clk) disable iff (!arst_n)
		accept |-> ##1 !ready ##1 !ready ##1 !ready ##1 ready)
	else begin
		$error("ready was not low for exactly three cycles after acceptance");
		fail_count++;
	end

	// Every done answers a strobe accepted three edges earlier
	done_after_accept: assert property (@(posedge cpu_clk) disable iff (!arst_n)
		done |-> $past(accept, 3))
	else begin
		$error("done rose without an instruction accepted three cycles before");
		fail_count++;
	end

	// PC moves only with a completing instruction
	pc_only_on_done: assert property (@(posedge cpu_clk) disable iff (!arst_n)
		!$stable(pc) |-> done)
	else begin
		$error("pc changed outside the done cycle");
		fail_count++;
	end

endmodule

bind chip8_exec_top chip8_exec_props props_i (
	.cpu_clk     (cpu_clk),
	.arst_n      (arst_n),
	.instr_valid (instr_valid),
	.ready       (ready),
	.done        (done),
	.pc          (pc)
);

//--- tests/chip8_exec_tb.sv
// Self-checking testbench; one instruction at a time, inputs change only on falling edges
`timescale 1ns/1ps

module chip8_exec_tb;

	localparam logic [11:0] PC_RESET = 12'h200;

	// Test lengths, the watchdog limit follows from them
	localparam int N_LOAD     = 8;
	localparam int N_ALU_ITER = 4;
	localparam int N_BR_ITER  = 4;
	localparam int N_I_ITER   = 3;
	localparam int N_DROP     = 8;
	localparam int N_SCANS    = 3;
	localparam int N_INSTR    = 1 + 2 * N_LOAD + 9 * 3 * N_ALU_ITER + 6 * N_BR_ITER + 8
		+ 4 * N_I_ITER + N_DROP;
	localparam int TIMEOUT_CYCLES = N_INSTR * 5 + N_SCANS * 16 + 50;

	localparam logic [3:0] ALU_FNS [9] = '{
		chip8_isa_pkg::FN_MOV, chip8_isa_pkg::FN_OR, chip8_isa_pkg::FN_AND,
		chip8_isa_pkg::FN_XOR, chip8_isa_pkg::FN_ADD, chip8_isa_pkg::FN_SUB,
		chip8_isa_pkg::FN_SHR, chip8_isa_pkg::FN_SUBN, chip8_isa_pkg::FN_SHL
	};

	localparam logic [15:0] DROPPED [N_DROP] = '{
		16'hD123, 16'hF533, 16'h2345, 16'h00E0, 16'hC0FF, 16'hE09E, 16'hF007, 16'h812F
	};

	logic                  cpu_clk;
	logic                  arst_n;
	logic                  instr_valid;
	chip8_isa_pkg::instr_t instr;
	logic                  ready;
	logic                  done;
	logic [11:0]           pc;
	logic [11:0]           i_reg;
	logic [3:0]            peek_addr;
	logic [7:0]            peek_data;

	// Reference state
	logic [7:0]  v_model [16];
	logic [11:0] i_model;
	logic [11:0] pc_model;

	logic [31:0] rnd;
	int          checks;
	int          value_errors;
	int          issued;
	int unsigned cycle_count = 0;

	tb_clock_gen #(
		.PERIOD_NS    (10),
		.RESET_CYCLES (3)
	) clock_gen_i (
		.cpu_clk (cpu_clk),
		.arst_n  (arst_n)
	);

	chip8_exec_top #(
		.PC_RESET (PC_RESET)
	) chip8_exec_top_i (
		.cpu_clk     (cpu_clk),
		.arst_n      (arst_n),
		.instr_valid (instr_valid),
		.instr       (instr),
		.ready       (ready),
		.done        (done),
		.pc          (pc),
		.i_reg       (i_reg),
		.peek_addr   (peek_addr),
		.peek_data   (peek_data)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] t;
		t = s ^ (s << 13);
		t = t ^ (t >> 17);
		t = t ^ (t << 5);
		return t;
	endfunction

	task automatic check_value(input string name, input logic [11:0] got,
		input logic [11:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("error %s: got %h expected %h", name, got, exp);
			value_errors++;
		end
	endtask

	// Expected effect of one instruction on V, I and PC
	task automatic apply_model(input logic [15:0] w);
		logic [3:0]  x;
		logic [3:0]  y;
		logic [3:0]  n;
		logic [7:0]  kk;
		logic [7:0]  vx;
		logic [7:0]  vy;
		logic [7:0]  res;
		logic [8:0]  wide;
		logic        flag;
		logic        res_wr;
		logic        flag_wr;
		logic [11:0] pc_next;
		x       = w[11:8];
		y       = w[7:4];
		n       = w[3:0];
		kk      = w[7:0];
		vx      = v_model[x];
		vy      = v_model[y];
		res     = vx;
		flag    = 1'b0;
		res_wr  = 1'b0;
		flag_wr = 1'b0;
		pc_next = pc_model + 12'd2;
		case (w[15:12])
			4'h1: pc_next = w[11:0];
			4'h3: if (vx == kk) pc_next = pc_model + 12'd4;
			4'h4: if (vx != kk) pc_next = pc_model + 12'd4;
			4'h5: if (n == 4'h0 && vx == vy) pc_next = pc_model + 12'd4;
			4'h9: if (n == 4'h0 && vx != vy) pc_next = pc_model + 12'd4;
			4'h6: v_model[x] = kk;
			// No carry out on the immediate add
			4'h7: v_model[x] = vx + kk;
			4'h8: begin
				res_wr = 1'b1;
				case (n)
					4'h0: res = vy;
					4'h1: res = vx | vy;
					4'h2: res = vx & vy;
					4'h3: res = vx ^ vy;
					4'h4: begin
						wide    = {1'b0, vx} + {1'b0, vy};
						res     = wide[7:0];
						flag    = wide[8];
						flag_wr = 1'b1;
					end
					4'h5: begin
						res     = vx - vy;
						flag    = (vx >= vy);
						flag_wr = 1'b1;
					end
					4'h6: begin
						res     = vx >> 1;
						flag    = vx[0];
						flag_wr = 1'b1;
					end
					4'h7: begin
						res     = vy - vx;
						flag    = (vy >= vx);
						flag_wr = 1'b1;
					end
					4'hE: begin
						res     = vx << 1;
						flag    = vx[7];
						flag_wr = 1'b1;
					end
					default: res_wr = 1'b0;
				endcase
				if (res_wr) v_model[x] = res;
				// Flag last, so it wins for x = F
				if (flag_wr) v_model[15] = {7'b0, flag};
			end
			4'hA: i_model = w[11:0];
			4'hB: pc_next = w[11:0] + {4'h0, v_model[0]};
			4'hF: begin
				if (kk == 8'h1E) i_model = i_model + {4'h0, vx};
				else if (kk == 8'h29) i_model = {8'h0, vx[3:0]} * 12'd5;
			end
			default: ;
		endcase
		pc_model = pc_next;
	endtask

	// Issue one word, wait for done, then check PC, I, Vx and VF
	task automatic run_instr(input logic [15:0] word, input logic stray_strobe);
		logic [3:0] x;
		x = word[11:8];
		while (!ready) @(negedge cpu_clk);
		instr       = word;
		instr_valid = 1'b1;
		peek_addr   = x;
		@(negedge cpu_clk);
		if (stray_strobe) begin
			// Second strobe while busy, must be dropped
			instr = word ^ 16'h00FF;
			check_value("ready", {11'h0, ready}, 12'h000);
			@(negedge cpu_clk);
		end
		instr_valid = 1'b0;
		apply_model(word);
		issued++;
		while (!done) @(negedge cpu_clk);
		check_value("pc", pc, pc_model);
		check_value("i_reg", i_reg, i_model);
		check_value($sformatf("peek_data V%h", x), {4'h0, peek_data}, {4'h0, v_model[x]});
		peek_addr = 4'hF;
		@(negedge cpu_clk);
		check_value("peek_data VF", {4'h0, peek_data}, {4'h0, v_model[15]});
	endtask

	// All sixteen V registers, one per cycle
	task automatic scan_regs();
		for (int r = 0; r < 16; r++) begin
			peek_addr = r[3:0];
			@(negedge cpu_clk);
			check_value($sformatf("peek_data V%h", r[3:0]), {4'h0, peek_data},
				{4'h0, v_model[r]});
		end
	endtask

	always @(posedge cpu_clk) begin
		cycle_count++;
		if (cycle_count > TIMEOUT_CYCLES) begin
			$display("run stopped: cycle limit of %0d reached before the tests ended",
				TIMEOUT_CYCLES);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	initial begin : stimulus
		logic [3:0] x;
		logic [3:0] y;
		logic [7:0] a;
		logic [7:0] b;
		logic       taken;
		instr_valid  = 1'b0;
		instr        = '0;
		peek_addr    = '0;
		rnd          = 32'd12;
		checks       = 0;
		value_errors = 0;
		issued       = 0;
		for (int r = 0; r < 16; r++) begin
			v_model[r] = 8'h00;
		end
		i_model  = 12'h000;
		pc_model = PC_RESET;
		@(posedge arst_n);
		@(negedge cpu_clk);

		// Reset state, then a dropped strobe
		check_value("ready", {11'h0, ready}, 12'h001);
		check_value("done", {11'h0, done}, 12'h000);
		check_value("pc", pc, PC_RESET);
		check_value("i_reg", i_reg, 12'h000);
		scan_regs();
		run_instr(16'h6123, 1'b1);

		// Immediate load and add, VF left alone
		for (int k = 0; k < N_LOAD; k++) begin
			rnd = xorshift32(rnd);
			x   = (rnd[3:0] == 4'hF) ? 4'hE : rnd[3:0];
			run_instr({chip8_isa_pkg::CLS_LD_IMM, x, rnd[15:8]}, 1'b0);
			run_instr({chip8_isa_pkg::CLS_ADD_IMM, x, rnd[23:16] | 8'h80}, 1'b0);
		end

		// 8xy group, last pass of each uses x = F
		for (int f = 0; f < 9; f++) begin
			for (int it = 0; it < N_ALU_ITER; it++) begin
				rnd = xorshift32(rnd);
				x   = (it == N_ALU_ITER - 1) ? 4'hF : {1'b0, rnd[2:0]};
				y   = {1'b1, rnd[6:4]};
				run_instr({chip8_isa_pkg::CLS_LD_IMM, x, rnd[15:8]}, 1'b0);
				run_instr({chip8_isa_pkg::CLS_LD_IMM, y, rnd[23:16]}, 1'b0);
				run_instr({chip8_isa_pkg::CLS_ALU, x, y, ALU_FNS[f]}, 1'b0);
			end
		end
		scan_regs();

		// Skips, taken and not taken
		for (int it = 0; it < N_BR_ITER; it++) begin
			rnd   = xorshift32(rnd);
			taken = (it % 2 == 0);
			x     = {1'b0, rnd[2:0]};
			y     = {1'b1, rnd[6:4]};
			a     = rnd[15:8];
			b     = taken ? a : a ^ 8'h5A;
			run_instr({chip8_isa_pkg::CLS_LD_IMM, x, a}, 1'b0);
			run_instr({chip8_isa_pkg::CLS_LD_IMM, y, b}, 1'b0);
			run_instr({chip8_isa_pkg::CLS_SE_IMM, x, taken ? a : ~a}, 1'b0);
			run_instr({chip8_isa_pkg::CLS_SNE_IMM, x, taken ? ~a : a}, 1'b0);
			run_instr({chip8_isa_pkg::CLS_SE_REG, x, y, 4'h0}, 1'b0);
			run_instr({chip8_isa_pkg::CLS_SNE_REG, x, y, 4'h0}, 1'b0);
		end

		// Jumps, the V0 offset usually wraps past FFF
		for (int it = 0; it < 2; it++) begin
			rnd = xorshift32(rnd);
			run_instr({chip8_isa_pkg::CLS_JP, rnd[11:0]}, 1'b0);
		end
		for (int it = 0; it < 3; it++) begin
			rnd = xorshift32(rnd);
			run_instr({chip8_isa_pkg::CLS_LD_IMM, 4'h0, rnd[7:0]}, 1'b0);
			run_instr({chip8_isa_pkg::CLS_JP_V0, 4'hF, rnd[15:8]}, 1'b0);
		end

		// Index register, Fx1E starts near the top to wrap
		for (int it = 0; it < N_I_ITER; it++) begin
			rnd = xorshift32(rnd);
			x   = {1'b0, rnd[2:0]};
			run_instr({chip8_isa_pkg::CLS_LD_I, 4'hF, rnd[15:8]}, 1'b0);
			run_instr({chip8_isa_pkg::CLS_LD_IMM, x, rnd[23:16] | 8'h80}, 1'b0);
			run_instr({chip8_isa_pkg::CLS_MISC_F, x, chip8_isa_pkg::FSEL_ADD_I}, 1'b0);
			run_instr({chip8_isa_pkg::CLS_MISC_F, x, chip8_isa_pkg::FSEL_LD_F}, 1'b0);
		end

		// Opcodes outside the core only step the PC
		for (int d = 0; d < N_DROP; d++) begin
			run_instr(DROPPED[d], 1'b0);
		end
		scan_regs();

		$display("summary: %0d instructions, %0d checks, %0d value errors, %0d assertion errors",
			issued, checks, value_errors, chip8_exec_top_i.props_i.fail_count);
		if (value_errors == 0 && chip8_exec_top_i.props_i.fail_count == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

//--- tests/tb_clock_gen.sv
// Free-running testbench clock; reset is held low over the first RESET_CYCLES rising edges
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int PERIOD_NS    = 10,
	parameter int RESET_CYCLES = 3
) (
	output logic cpu_clk,
	output logic arst_n
);

	initial begin
		cpu_clk = 1'b0;
		forever #(PERIOD_NS / 2) cpu_clk = ~cpu_clk;
	end

	// Release on a falling edge, away from the sampling edge
	initial begin
		arst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge cpu_clk);
		@(negedge cpu_clk);
		arst_n = 1'b1;
	end

endmodule
